/* design/blk_pkg.sv */
/*
 * shared definitions of the block-transfer engine
 *   memory sizes and port count
 *   address, word and length types
 *   opcode enum and controller state enum
 */

`default_nettype none

package blk_pkg;

	// memory geometry
	localparam int addr_bits = 4;
	localparam int word_bits = 8;
	localparam int num_words = 2 ** addr_bits;
	// port 0 reads, port 1 writes
	localparam int num_ports = 2;

	typedef logic [addr_bits - 1 : 0] addr_t;
	typedef logic [word_bits - 1 : 0] word_t;
	// one extra bit so a full-memory length fits
	typedef logic [addr_bits : 0] len_t;

	// host operations
	typedef enum logic [2 : 0] {
		op_write,
		op_read,
		op_fill,
		op_copy,
		op_sum
	} blk_op_t;

	// controller states
	typedef enum logic [1 : 0] {
		st_idle,
		st_run,
		st_drain,
		st_done
	} ctrl_state_t;

endpackage

`default_nettype wire

/* design/mem_port_if.sv */
/*
 * interfaces of the block-transfer engine
 *   mem_port_if: one RAM port, enables, address and data
 *   seq_if: address sequencing between controller and counter
 */

`timescale 1ns/100ps
`default_nettype none

interface mem_port_if import blk_pkg::*; ();
	logic read_ena;
	logic write_ena;
	addr_t addr;
	word_t wdata;
	// registered read data, zero when not read
	word_t rdata;

	modport master(output read_ena, write_ena, addr, wdata, input rdata);
	modport mem(input read_ena, write_ena, addr, wdata, output rdata);
endinterface

interface seq_if import blk_pkg::*; ();
	logic load;
	logic step;
	addr_t src_addr;
	addr_t dst_addr;
	// final word of the range, or an empty range on load
	logic last;

	modport ctrl(output load, step, input last);
	modport count(input load, step, output src_addr, dst_addr, last);
	modport view(input src_addr, dst_addr);
endinterface

`default_nettype wire

/* design/ram.sv */
/*
 * multi-port synchronous RAM
 *   one write and one registered read per port and clock
 *   read output is zero when the port does not read
 *   a read of the word written in the same cycle returns the old word
 */

`timescale 1ns/100ps
`default_nettype none

module ram #(
	parameter int num_ports = 2,
	parameter int addr_bits = 4,
	parameter int word_bits = 8,
	parameter int num_words = 2 ** addr_bits
) (
	input wire logic in_clk,
	input wire logic in_rst,
	mem_port_if.mem ports [num_ports]
);

	// port signals pulled out of the interface array
	logic [num_ports - 1 : 0] read_ena;
	logic [num_ports - 1 : 0] write_ena;
	logic [addr_bits - 1 : 0] addr [num_ports];
	logic [word_bits - 1 : 0] wdata [num_ports];

	// read data registers
	logic [word_bits - 1 : 0] rdata [num_ports];

	// storage, no reset
	logic [word_bits - 1 : 0] words [num_words];

	for (genvar p = 0; p < num_ports; p++) begin : gen_port
		assign read_ena[p] = ports[p].read_ena;
		assign write_ena[p] = ports[p].write_ena;
		assign addr[p] = ports[p].addr;
		assign wdata[p] = ports[p].wdata;
		assign ports[p].rdata = rdata[p];
	end

	// writes, each port on its own enable
	// higher port wins on an address clash
	always_ff @(posedge in_clk) begin
		for (int p = 0; p < num_ports; p++) begin
			if (write_ena[p]) begin
				words[addr[p]] <= wdata[p];
			end
		end
	end

	// registered reads
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			for (int p = 0; p < num_ports; p++) begin
				rdata[p] <= '0;
			end
		end else begin
			for (int p = 0; p < num_ports; p++) begin
				if (read_ena[p]) begin
					rdata[p] <= words[addr[p]];
				end else begin
					// idle port reads as zero
					rdata[p] <= '0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/addr_counter.sv */
/*
 * address counter
 *   source and destination address, both wrapping
 *   remaining word count and the last-word flag
 */

`timescale 1ns/100ps
`default_nettype none

module addr_counter import blk_pkg::*; (
	input wire logic in_clk,
	input wire logic in_rst,
	seq_if.count seq,
	input wire addr_t in_addr_a,
	input wire addr_t in_addr_b,
	input wire len_t in_len
);

	addr_t src_addr;
	addr_t dst_addr;
	// words still to go, including the current one
	len_t count;

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			src_addr <= '0;
			dst_addr <= '0;
			count <= '0;
		end else if (seq.load) begin
			src_addr <= in_addr_a;
			dst_addr <= in_addr_b;
			count <= in_len;
		end else if (seq.step) begin
			// 4-bit adds wrap modulo the memory size
			src_addr <= src_addr + addr_t'(1);
			dst_addr <= dst_addr + addr_t'(1);
			if (count != '0) begin
				count <= count - len_t'(1);
			end
		end
	end

	assign seq.src_addr = src_addr;
	assign seq.dst_addr = dst_addr;

	// during load, flag an empty range straight from the host length
	// so the controller can skip the run phase
	// otherwise flag the final word of the range
	always_comb begin
		if (seq.load) begin
			seq.last = (in_len == '0);
		end else begin
			seq.last = (count <= len_t'(1));
		end
	end

endmodule

`default_nettype wire

/* design/blk_ctrl.sv */
/*
 * engine controller
 *   idle, run, drain and done FSM
 *   per-opcode read, write, accumulate and capture strobes
 *   registered busy level and done pulse
 */

`timescale 1ns/100ps
`default_nettype none

module blk_ctrl import blk_pkg::*; (
	input wire logic in_clk,
	input wire logic in_rst,
	input wire logic in_start,
	input wire blk_op_t in_op,
	seq_if.ctrl seq,
	output logic rd_en,
	output logic wr_en,
	output logic acc_clear,
	output logic acc_add,
	output logic capture,
	output logic busy,
	output logic done
);

	ctrl_state_t state;
	ctrl_state_t state_next;

	// opcode of the running operation
	blk_op_t op_q;

	// read strobe delayed to line up with read data
	logic rd_q;

	// write and read touch a single word
	logic single_in;
	logic single_q;

	assign single_in = (in_op == op_write) || (in_op == op_read);
	assign single_q = (op_q == op_write) || (op_q == op_read);

	// start only counts in idle
	assign seq.load = (state == st_idle) && in_start;
	assign seq.step = (state == st_run);

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (in_start) begin
					// empty range goes straight to drain
					if (seq.last && !single_in) begin
						state_next = st_drain;
					end else begin
						state_next = st_run;
					end
				end
			end
			st_run: begin
				if (seq.last || single_q) begin
					state_next = st_drain;
				end
			end
			st_drain: begin
				state_next = st_done;
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= st_idle;
			op_q <= op_write;
			rd_q <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			state <= state_next;
			if (seq.load) begin
				op_q <= in_op;
			end
			rd_q <= rd_en;
			// flags follow the next state, so they line up with it
			busy <= (state_next == st_run) || (state_next == st_drain);
			done <= (state_next == st_done);
		end
	end

	// one read per run cycle for read, copy and sum
	assign rd_en = (state == st_run) &&
		((op_q == op_read) || (op_q == op_copy) || (op_q == op_sum));

	// write and fill write directly, copy one cycle behind its read
	assign wr_en = ((state == st_run) && ((op_q == op_write) || (op_q == op_fill))) ||
		(rd_q && (op_q == op_copy));

	// accumulator held at zero while idle
	assign acc_clear = (state == st_idle);
	assign acc_add = rd_q && (op_q == op_sum);

	// last read data or final sum is taken in drain
	assign capture = (state == st_drain) && ((op_q == op_read) || (op_q == op_sum));

endmodule

`default_nettype wire

/* design/blk_datapath.sv */
/*
 * engine datapath
 *   read and write RAM port drive
 *   delayed destination address and write data select
 *   modulo-256 accumulator and result register
 */

`timescale 1ns/100ps
`default_nettype none

module blk_datapath import blk_pkg::*; (
	input wire logic in_clk,
	input wire logic in_rst,
	input wire logic in_start,
	input wire blk_op_t in_op,
	input wire word_t in_data,
	seq_if.view seq,
	input wire logic rd_en,
	input wire logic wr_en,
	input wire logic acc_clear,
	input wire logic acc_add,
	input wire logic capture,
	mem_port_if.master rd_port,
	mem_port_if.master wr_port,
	output word_t result
);

	blk_op_t op_q;
	word_t data_q;
	// destination one cycle behind, matches read latency
	addr_t dst_q;
	word_t acc;
	word_t acc_next;

	// host word and destination, payload only
	always_ff @(posedge in_clk) begin
		// acc_clear marks idle, so this is an accepted start
		if (in_start && acc_clear) begin
			data_q <= in_data;
		end
		dst_q <= seq.dst_addr;
	end

	// read port only reads
	assign rd_port.read_ena = rd_en;
	assign rd_port.write_ena = 1'b0;
	assign rd_port.addr = seq.src_addr;
	assign rd_port.wdata = '0;

	// write port only writes
	assign wr_port.read_ena = 1'b0;
	assign wr_port.write_ena = wr_en;
	assign wr_port.addr = (op_q == op_copy) ? dst_q : seq.dst_addr;
	assign wr_port.wdata = (op_q == op_copy) ? rd_port.rdata : data_q;

	// sum wraps at 8 bits
	assign acc_next = acc_add ? (acc + rd_port.rdata) : acc;

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			op_q <= op_write;
			acc <= '0;
			result <= '0;
		end else begin
			if (in_start && acc_clear) begin
				op_q <= in_op;
			end
			if (acc_clear) begin
				acc <= '0;
			end else begin
				acc <= acc_next;
			end
			// includes the final add of a sum
			if (capture) begin
				result <= (op_q == op_sum) ? acc_next : rd_port.rdata;
			end
		end
	end

endmodule

`default_nettype wire

/* design/blk_engine.sv */
/*
 * block-transfer engine top level
 *   counter, controller, datapath and dual-port RAM
 *   plain host ports, interface wiring inside
 */

`timescale 1ns/100ps
`default_nettype none

module blk_engine import blk_pkg::*; (
	input wire logic in_clk,
	input wire logic in_rst,
	input wire logic in_start,
	input wire blk_op_t in_op,
	input wire addr_t in_addr_a,
	input wire addr_t in_addr_b,
	input wire len_t in_len,
	input wire word_t in_data,
	output logic out_busy,
	output logic out_done,
	output word_t out_result
);

	// controller strobes to the datapath
	logic rd_en;
	logic wr_en;
	logic acc_clear;
	logic acc_add;
	logic capture;

	seq_if seq ();
	// index 0 is the read port, 1 the write port
	mem_port_if mem_ports [num_ports] ();

	addr_counter u_cnt (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.seq(seq),
		.in_addr_a(in_addr_a),
		.in_addr_b(in_addr_b),
		.in_len(in_len)
	);

	blk_ctrl u_ctrl (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.in_start(in_start),
		.in_op(in_op),
		.seq(seq),
		.rd_en(rd_en),
		.wr_en(wr_en),
		.acc_clear(acc_clear),
		.acc_add(acc_add),
		.capture(capture),
		.busy(out_busy),
		.done(out_done)
	);

	blk_datapath u_dp (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.in_start(in_start),
		.in_op(in_op),
		.in_data(in_data),
		.seq(seq),
		.rd_en(rd_en),
		.wr_en(wr_en),
		.acc_clear(acc_clear),
		.acc_add(acc_add),
		.capture(capture),
		.rd_port(mem_ports[0]),
		.wr_port(mem_ports[1]),
		.result(out_result)
	);

	ram #(
		.num_ports(num_ports),
		.addr_bits(addr_bits),
		.word_bits(word_bits),
		.num_words(num_words)
	) u_ram (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.ports(mem_ports)
	);

endmodule

`default_nettype wire

/* bench/blk_engine_checker.sv */
/*
 * flag assertions for the block-transfer engine
 *   done and busy are never high together
 *   done is a single-cycle pulse
 *   an accepted start raises busy on the next cycle
 */

`timescale 1ns/100ps
`default_nettype none

module blk_engine_checker (
	input wire logic in_clk,
	input wire logic in_rst,
	input wire logic in_start,
	input wire logic out_busy,
	input wire logic out_done
);

	// engine is idle when neither busy nor signalling done
	logic idle;

	assign idle = !out_busy && !out_done;

	done_not_busy: assert property (@(posedge in_clk) disable iff (in_rst)
		out_done |-> !out_busy)
		else $error("done and busy high in the same cycle");

	done_one_cycle: assert property (@(posedge in_clk) disable iff (in_rst)
		out_done |=> !out_done)
		else $error("done held for more than one cycle");

	// start sampled in idle is accepted
	start_gives_busy: assert property (@(posedge in_clk) disable iff (in_rst)
		(in_start && idle) |=> out_busy)
		else $error("accepted start not followed by busy");

endmodule

`default_nettype wire

/* bench/blk_engine_tb.sv */
/*
 * testbench of the block-transfer engine
 *   clock, reset and LFSR stimulus driven on the falling edge
 *   memory model, latency checks, start-while-busy injection
 *   compare tasks and a cycle-count timeout
 */

`timescale 1ns/100ps
`default_nettype none

module blk_engine_tb import blk_pkg::*; ();

	localparam int reset_cycles = 8;
	localparam int num_single = 16;
	localparam int num_copy = 6;
	localparam int num_sum = 10;
	// fill with readback, single triples, scramble, copies with readback, sums
	localparam int num_ops = (1 + num_words) + 3 * num_single + num_words +
		num_copy * (1 + num_words) + (num_sum + 2);
	localparam int timeout_limit = num_ops * (num_words + 3) + reset_cycles + 200;

	logic in_clk;
	logic in_rst;
	logic in_start;
	blk_op_t in_op;
	addr_t in_addr_a;
	addr_t in_addr_b;
	len_t in_len;
	word_t in_data;
	logic out_busy;
	logic out_done;
	word_t out_result;

	// reference copy of the RAM
	word_t model_mem [num_words];
	logic [31:0] lfsr = 32'hb192e2e0;
	int cycle_count = 0;

	blk_engine dut (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.in_start(in_start),
		.in_op(in_op),
		.in_addr_a(in_addr_a),
		.in_addr_b(in_addr_b),
		.in_len(in_len),
		.in_data(in_data),
		.out_busy(out_busy),
		.out_done(out_done),
		.out_result(out_result)
	);

	bind blk_engine blk_engine_checker flag_checks (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.in_start(in_start),
		.out_busy(out_busy),
		.out_done(out_done)
	);

	initial begin
		in_clk = 1'b0;
		forever #20 in_clk = ~in_clk;
	end

	// stop with the fail message
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	always @(posedge in_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			abort_run($sformatf("timeout, done never came within %0d cycles", timeout_limit));
		end
	end

	// fibonacci LFSR on taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			abort_run($sformatf("FAILED %s: expected %0h, actual %0h", name, exp, act));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("FAILED %s: expected %0b, actual %0b", name, exp, act));
		end
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		if (act != exp) begin
			abort_run($sformatf("FAILED %s: expected %0d cycles, actual %0d", name, exp, act));
		end
	endtask

	// one operation from start to done with an optional ignored start while busy
	task automatic run_op(input string name, input blk_op_t op, input addr_t a,
		input addr_t b, input len_t len, input word_t data);
		int cycles;
		int expected;
		logic poke;
		poke = random_bits(1) != 0;
		// single-word ops count as length 1
		expected = ((op == op_write) || (op == op_read)) ? 3 : int'(len) + 2;
		@(negedge in_clk);
		in_start = 1'b1;
		in_op = op;
		in_addr_a = a;
		in_addr_b = b;
		in_len = len;
		in_data = data;
		cycles = 0;
		do begin
			@(posedge in_clk);
			cycles++;
			@(negedge in_clk);
			in_start = 1'b0;
			if (!out_done) begin
				check_flag({name, " busy"}, 1'b1, out_busy);
				// full fill while busy that the engine must ignore
				if (poke && cycles == 1) begin
					in_start = 1'b1;
					in_op = op_fill;
					in_addr_b = addr_t'(random_bits(addr_bits));
					in_len = len_t'(num_words);
					in_data = word_t'(random_bits(word_bits));
				end
			end
		end while (!out_done && cycles <= expected);
		check_cycles({name, " latency"}, expected, cycles);
		check_flag({name, " busy at done"}, 1'b0, out_busy);
	endtask

	task automatic do_write(input addr_t b, input word_t data);
		run_op($sformatf("write %0h", b), op_write, '0, b, len_t'(1), data);
		model_mem[b] = data;
	endtask

	task automatic do_read(input string name, input addr_t a);
		run_op(name, op_read, a, '0, len_t'(1), '0);
		check_word(name, model_mem[a], out_result);
	endtask

	task automatic do_fill(input addr_t b, input len_t len, input word_t data);
		run_op("fill", op_fill, '0, b, len, data);
		for (int i = 0; i < int'(len); i++) begin
			model_mem[addr_t'(b + i)] = data;
		end
	endtask

	task automatic do_copy(input addr_t a, input addr_t b, input int len);
		run_op("copy", op_copy, a, b, len_t'(len), '0);
		for (int i = 0; i < len; i++) begin
			model_mem[addr_t'(b + i)] = model_mem[addr_t'(a + i)];
		end
		// both ranges read back
		for (int i = 0; i < len; i++) begin
			do_read("copy source", addr_t'(a + i));
			do_read("copy destination", addr_t'(b + i));
		end
	endtask

	task automatic do_sum(input addr_t a, input int len);
		word_t sum;
		string name;
		sum = '0;
		name = $sformatf("sum %0h len %0d", a, len);
		// 8-bit add wraps modulo 256
		for (int i = 0; i < len; i++) begin
			sum = sum + model_mem[addr_t'(a + i)];
		end
		run_op(name, op_sum, a, '0, len_t'(len), '0);
		check_word(name, sum, out_result);
	endtask

	initial begin
		addr_t a;
		addr_t b;
		int len;
		int gap;
		in_rst = 1'b1;
		in_start = 1'b0;
		in_op = op_write;
		in_addr_a = '0;
		in_addr_b = '0;
		in_len = '0;
		in_data = '0;
		repeat (reset_cycles) @(posedge in_clk);
		@(negedge in_clk);
		in_rst = 1'b0;
		check_flag("reset busy", 1'b0, out_busy);
		check_flag("reset done", 1'b0, out_done);
		check_word("reset result", '0, out_result);

		// whole memory from a random start so the range wraps
		do_fill(addr_t'(random_bits(addr_bits)), len_t'(num_words),
			word_t'(random_bits(word_bits)));
		for (int i = 0; i < num_words; i++) begin
			do_read("fill readback", addr_t'(i));
		end

		repeat (num_single) begin
			a = addr_t'(random_bits(addr_bits));
			do_write(a, word_t'(random_bits(word_bits)));
			do_read("single readback", a);
			do_read("single random read", addr_t'(random_bits(addr_bits)));
		end

		// distinct words so copies move real data
		for (int i = 0; i < num_words; i++) begin
			do_write(addr_t'(i), word_t'(random_bits(word_bits)));
		end

		// destination starts past the source so the ranges never meet
		repeat (num_copy) begin
			len = 1 + int'(random_bits(3));
			gap = int'(random_bits(addr_bits)) % (num_words + 1 - 2 * len);
			a = addr_t'(random_bits(addr_bits));
			b = addr_t'(a + len + gap);
			do_copy(a, b, len);
		end

		do_sum(addr_t'(random_bits(addr_bits)), 0);
		do_sum(addr_t'(random_bits(addr_bits)), num_words);
		repeat (num_sum) begin
			do_sum(addr_t'(random_bits(addr_bits)), int'(random_bits(5)) % (num_words + 1));
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
design/blk_pkg.sv
design/mem_port_if.sv
design/ram.sv
design/addr_counter.sv
design/blk_ctrl.sv
design/blk_datapath.sv
design/blk_engine.sv
bench/blk_engine_checker.sv
bench/blk_engine_tb.sv

/* run.sh */
#!/bin/sh
# build and run the block-transfer engine testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f compile.f \
	--top-module blk_engine_tb \
	-Mdir obj_dir \
	-o blk_engine_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/blk_engine_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
